/* hdl/fp_fmt_pkg.sv */
package fp_fmt_pkg;

  ////////////////////////////////////////
  // Field widths
  ////////////////////////////////////////

  localparam int exp_w32  = 8;   // FP32 exponent
  localparam int mant_w32 = 23;  // FP32 stored mantissa
  localparam int exp_w16  = 5;   // FP16 exponent
  localparam int mant_w16 = 10;  // FP16 stored mantissa

  // One-bit format select
  localparam logic fmt_fp32 = 1'b0;
  localparam logic fmt_fp16 = 1'b1;

  // Upper half of a boxed FP16 result
  localparam logic [15:0] box16 = 16'hffff;

  // Quiet NaN payload, top stored bit only
  localparam logic [mant_w32-1:0] canon_nan_mant32 = {1'b1, {(mant_w32-1){1'b0}}};
  localparam logic [mant_w16-1:0] canon_nan_mant16 = {1'b1, {(mant_w16-1){1'b0}}};

  ////////////////////////////////////////
  // Result word, two decodings
  ////////////////////////////////////////

  typedef union packed {
    struct packed {
      logic                sign;
      logic [exp_w32-1:0]  exp;
      logic [mant_w32-1:0] mant;
    } fp32;
    struct packed {
      logic [15:0]         box;   // All ones when valid FP16
      logic                sign;
      logic [exp_w16-1:0]  exp;
      logic [mant_w16-1:0] mant;
    } fp16;
  } fp_word_u;

endpackage

/* hdl/fp_round_pkg.sv */
package fp_round_pkg;

  ////////////////////////////////////////
  // Rounding modes
  ////////////////////////////////////////

  localparam logic [1:0] rm_nearest_even = 2'd0;
  localparam logic [1:0] rm_to_zero      = 2'd1;
  localparam logic [1:0] rm_plus_inf     = 2'd2;
  localparam logic [1:0] rm_minus_inf    = 2'd3;

  // Bit positions in the five-bit flag word
  localparam int flag_nv = 4;  // Invalid
  localparam int flag_dz = 3;  // Divide by zero
  localparam int flag_of = 2;  // Overflow
  localparam int flag_uf = 1;  // Underflow
  localparam int flag_nx = 0;  // Inexact

  ////////////////////////////////////////
  // Datapath input widths
  ////////////////////////////////////////

  // Hidden bit, 23 fraction bits and 4 rounding bits
  localparam int mant_in_w = 28;
  // Signed biased exponent from the divider
  localparam int exp_in_w  = 10;
  // Normalized mantissa incl. hidden bit
  localparam int norm_w    = 24;

endpackage

/* hdl/exc_classify.sv */
`timescale 1ns/10ps

module exc_classify
  import fp_fmt_pkg::*;
  import fp_round_pkg::*;
(
  input  logic                       sign_in,
  input  logic signed [exp_in_w-1:0] exp_in,
  input  logic [mant_in_w-1:0]       mant_in,
  input  logic                       div_en,
  input  logic                       sqrt_en,
  input  logic                       nan_a,
  input  logic                       nan_b,
  input  logic                       snan,
  input  logic                       inf_a,
  input  logic                       inf_b,
  input  logic                       zero_a,
  input  logic                       zero_b,
  input  logic                       fmt,
  output logic                       exc_hit,
  output logic                       exc_sign,
  output logic                       exc_exp_ones,
  output logic                       exc_nan,
  output logic [4:0]                 exc_flags
);

  logic signed [exp_in_w-1:0] exp_top;  // All-ones exponent of the format
  logic signed [exp_in_w-1:0] exp_lim;  // Below this nothing survives the shift
  logic                       exp_ovf;
  logic                       exp_tuf;

  ////////////////////////////////////////
  // Exponent range checks
  ////////////////////////////////////////

  always_comb
  begin
    if (fmt == fmt_fp32)
    begin
      exp_top = exp_in_w'((2 ** exp_w32) - 1);
      exp_lim = exp_in_w'(-mant_w32);
    end
    else
    begin
      exp_top = exp_in_w'((2 ** exp_w16) - 1);
      exp_lim = exp_in_w'(-mant_w16);
    end
  end

  // At the top exponent only 0.1x survives, by the left shift
  assign exp_ovf = (exp_in > exp_top) || ((exp_in == exp_top) && mant_in[mant_in_w-1]);
  assign exp_tuf = exp_in < exp_lim;

  ////////////////////////////////////////
  // Priority chain
  ////////////////////////////////////////

  always_comb
  begin
    exc_hit      = 1'b1;
    exc_sign     = sign_in;
    exc_exp_ones = 1'b0;
    exc_nan      = 1'b0;
    exc_flags    = '0;
    if (nan_a || nan_b)                 // NaN in, quiet NaN out
    begin
      exc_sign           = 1'b0;
      exc_exp_ones       = 1'b1;
      exc_nan            = 1'b1;
      exc_flags[flag_nv] = snan;
    end
    else if (div_en && inf_a && inf_b)  // Inf/Inf
    begin
      exc_sign           = 1'b0;
      exc_exp_ones       = 1'b1;
      exc_nan            = 1'b1;
      exc_flags[flag_nv] = 1'b1;
    end
    else if (inf_a)
    begin
      exc_exp_ones       = 1'b1;
      exc_flags[flag_of] = 1'b1;
    end
    else if (div_en && inf_b)
      exc_exp_ones = 1'b0;              // x/Inf, signed zero
    else if (div_en && zero_a && zero_b)
    begin
      exc_sign           = 1'b0;
      exc_exp_ones       = 1'b1;
      exc_nan            = 1'b1;
      exc_flags[flag_nv] = 1'b1;
      exc_flags[flag_dz] = 1'b1;
    end
    else if (zero_a)
      exc_exp_ones = 1'b0;              // Signed zero, no flags
    else if (div_en && zero_b)
    begin
      exc_exp_ones       = 1'b1;        // x/0 gives signed infinity
      exc_flags[flag_dz] = 1'b1;
    end
    else if (sqrt_en && sign_in)        // Root of a negative
    begin
      exc_sign           = 1'b0;
      exc_exp_ones       = 1'b1;
      exc_nan            = 1'b1;
      exc_flags[flag_nv] = 1'b1;
    end
    else if (exp_ovf)
    begin
      exc_exp_ones       = 1'b1;
      exc_flags[flag_of] = 1'b1;
    end
    else if (exp_tuf)                   // Flush to signed zero
    begin
      exc_flags[flag_uf] = 1'b1;
      exc_flags[flag_nx] = 1'b1;
    end
    else
      exc_hit = 1'b0;                   // Rounded path wins
  end

endmodule

/* hdl/mant_norm_round.sv */
`timescale 1ns/10ps

module mant_norm_round
  import fp_fmt_pkg::*;
  import fp_round_pkg::*;
(
  input  logic                       sign_in,
  input  logic signed [exp_in_w-1:0] exp_in,
  input  logic [mant_in_w-1:0]       mant_in,
  input  logic [1:0]                 rm,
  input  logic                       fmt,
  output logic [exp_w32-1:0]         rnd_exp,
  output logic [mant_w32-1:0]        rnd_mant,
  output logic                       rnd_uf,
  output logic                       rnd_nx
);

  localparam int lsb32 = mant_in_w - norm_w;        // Kept LSB, FP32
  localparam int lsb16 = mant_in_w - mant_w16 - 1;  // Kept LSB, FP16
  localparam int pad16 = mant_w32 - mant_w16;       // Zero fill under FP16 field

  logic                 denorm;
  logic [exp_in_w:0]    rs_amt;     // 1 - exp, denormal shift
  logic [mant_in_w-1:0] lost_mask;
  logic [mant_in_w-1:0] norm_full;  // Left-aligned normalized bits
  logic                 norm_lost;  // Bits shifted off the bottom
  logic [exp_w32-1:0]   norm_exp;

  logic [norm_w-1:0]    kept;
  logic [norm_w-1:0]    inc;        // One at the kept LSB
  logic                 guard;
  logic                 rbit;
  logic                 sticky;
  logic                 lsb_bit;
  logic                 round_up;
  logic [norm_w:0]      sum;
  logic                 carry;

  ////////////////////////////////////////
  // Normalization
  ////////////////////////////////////////

  // Exp 1 with top bit clear already sits as 0.1x, shift of zero
  assign denorm    = (exp_in <= 0) || ((exp_in == 1) && !mant_in[mant_in_w-1]);
  assign rs_amt    = (exp_in_w+1)'(1) - {exp_in[exp_in_w-1], exp_in};
  assign lost_mask = ~({mant_in_w{1'b1}} << rs_amt);

  always_comb
  begin
    if (denorm)
    begin
      norm_full = mant_in >> rs_amt;
      norm_lost = |(mant_in & lost_mask);
      norm_exp  = '0;
    end
    else if (mant_in[mant_in_w-1])      // 1.x as is
    begin
      norm_full = mant_in;
      norm_lost = 1'b0;
      norm_exp  = exp_in[exp_w32-1:0];
    end
    else                                // 0.1x
    begin
      norm_full = mant_in << 1;
      norm_lost = 1'b0;
      norm_exp  = exp_in[exp_w32-1:0] - 1'b1;
    end
  end

  ////////////////////////////////////////
  // Rounding
  ////////////////////////////////////////

  always_comb
  begin
    if (fmt == fmt_fp16)
    begin
      kept   = {norm_full[mant_in_w-1:lsb16], {pad16{1'b0}}};
      guard  = norm_full[lsb16-1];
      rbit   = norm_full[lsb16-2];
      sticky = (|norm_full[lsb16-3:0]) | norm_lost;
      inc    = norm_w'(1) << pad16;
    end
    else
    begin
      kept   = norm_full[mant_in_w-1:lsb32];
      guard  = norm_full[lsb32-1];
      rbit   = norm_full[lsb32-2];
      sticky = (|norm_full[lsb32-3:0]) | norm_lost;
      inc    = norm_w'(1);
    end
  end

  assign lsb_bit = |(kept & inc);
  assign rnd_nx  = guard | rbit | sticky;

  always_comb
  begin
    case (rm)
      rm_nearest_even: round_up = guard & (rbit | sticky | lsb_bit);
      rm_to_zero:      round_up = 1'b0;
      rm_plus_inf:     round_up = rnd_nx & ~sign_in;
      rm_minus_inf:    round_up = rnd_nx & sign_in;
      default:         round_up = 1'b0;
    endcase
  end

  assign sum   = {1'b0, kept} + (round_up ? {1'b0, inc} : '0);
  assign carry = sum[norm_w];

  // Carry means 10.0, renormalize by one
  assign rnd_mant = carry ? sum[norm_w-1:1] : sum[norm_w-2:0];
  // Denormal rounding into the hidden bit becomes the smallest normal
  assign rnd_exp  = denorm ? exp_w32'(sum[norm_w-1]) : norm_exp + exp_w32'(carry);
  assign rnd_uf   = denorm & (|mant_in);

endmodule

/* hdl/result_pack.sv */
`timescale 1ns/10ps

module result_pack
  import fp_fmt_pkg::*;
  import fp_round_pkg::*;
#(
  parameter int pipe_stages = 2
)
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  logic                sign_in,
  input  logic                fmt,
  input  logic                exc_hit,
  input  logic                exc_sign,
  input  logic                exc_exp_ones,
  input  logic                exc_nan,
  input  logic [4:0]          exc_flags,
  input  logic [exp_w32-1:0]  rnd_exp,
  input  logic [mant_w32-1:0] rnd_mant,
  input  logic                rnd_uf,
  input  logic                rnd_nx,
  output logic                out_valid,
  output fp_word_u            result,
  output logic [4:0]          fflags
);

  fp_word_u               word_m;
  logic [4:0]             flags_m;
  logic                   sign_m;
  fp_word_u               word_q  [pipe_stages];
  logic [4:0]             flags_q [pipe_stages];
  logic [pipe_stages-1:0] valid_q;

  ////////////////////////////////////////
  // Merge and pack
  ////////////////////////////////////////

  assign sign_m = exc_hit ? exc_sign : sign_in;

  always_comb
  begin
    flags_m          = '0;
    flags_m[flag_uf] = rnd_uf;
    flags_m[flag_nx] = rnd_nx;
    if (exc_hit)
      flags_m = exc_flags;              // Exception flags replace the rounded pair
  end

  always_comb
  begin
    if (fmt == fmt_fp16)
    begin
      word_m.fp16.box  = box16;
      word_m.fp16.sign = sign_m;
      word_m.fp16.exp  = exc_hit ? {exp_w16{exc_exp_ones}} : rnd_exp[exp_w16-1:0];
      if (exc_hit)
        word_m.fp16.mant = exc_nan ? canon_nan_mant16 : '0;
      else
        word_m.fp16.mant = rnd_mant[mant_w32-1 -: mant_w16];  // Left-aligned field
    end
    else
    begin
      word_m.fp32.sign = sign_m;
      word_m.fp32.exp  = exc_hit ? {exp_w32{exc_exp_ones}} : rnd_exp;
      if (exc_hit)
        word_m.fp32.mant = exc_nan ? canon_nan_mant32 : '0;
      else
        word_m.fp32.mant = rnd_mant;
    end
  end

  ////////////////////////////////////////
  // Output pipeline
  ////////////////////////////////////////

  // Payload advances only with its valid, so bubbles leave outputs held
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      valid_q <= '0;
      for (int i = 0; i < pipe_stages; i++)
      begin
        word_q[i]  <= '0;
        flags_q[i] <= '0;
      end
    end
    else
    begin
      valid_q[0] <= in_valid;
      if (in_valid)
      begin
        word_q[0]  <= word_m;
        flags_q[0] <= flags_m;
      end
      for (int i = 1; i < pipe_stages; i++)
      begin
        valid_q[i] <= valid_q[i-1];
        if (valid_q[i-1])
        begin
          word_q[i]  <= word_q[i-1];
          flags_q[i] <= flags_q[i-1];
        end
      end
    end
  end

  assign out_valid = valid_q[pipe_stages-1];
  assign result    = word_q[pipe_stages-1];
  assign fflags    = flags_q[pipe_stages-1];

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  a_stage_range: assert property (@(posedge clk) (pipe_stages >= 1) && (pipe_stages <= 3))
    else $error("pipe_stages %0d outside 1..3", pipe_stages);

  a_flags_known: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> !$isunknown(fflags))
    else $error("fflags unknown on a valid output");

endmodule

/* hdl/fp_norm_round_top.sv */
`timescale 1ns/10ps

module fp_norm_round_top
  import fp_fmt_pkg::*;
  import fp_round_pkg::*;
#(
  parameter int pipe_stages = 2
)
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       in_valid,
  input  logic                       sign_in,
  input  logic signed [exp_in_w-1:0] exp_in,
  input  logic [mant_in_w-1:0]       mant_in,
  input  logic                       div_en,
  input  logic                       sqrt_en,
  input  logic                       nan_a,
  input  logic                       nan_b,
  input  logic                       snan,
  input  logic                       inf_a,
  input  logic                       inf_b,
  input  logic                       zero_a,
  input  logic                       zero_b,
  input  logic [1:0]                 rm,
  input  logic                       fmt,
  output logic                       out_valid,
  output fp_word_u                   result,
  output logic [4:0]                 fflags
);

  // Exception path
  logic                exc_hit;
  logic                exc_sign;
  logic                exc_exp_ones;
  logic                exc_nan;
  logic [4:0]          exc_flags;

  // Rounded path
  logic [exp_w32-1:0]  rnd_exp;
  logic [mant_w32-1:0] rnd_mant;
  logic                rnd_uf;
  logic                rnd_nx;

  ////////////////////////////////////////
  // Two parallel paths into the packer
  ////////////////////////////////////////

  exc_classify u_exc_classify (
    .sign_in      (sign_in),
    .exp_in       (exp_in),
    .mant_in      (mant_in),
    .div_en       (div_en),
    .sqrt_en      (sqrt_en),
    .nan_a        (nan_a),
    .nan_b        (nan_b),
    .snan         (snan),
    .inf_a        (inf_a),
    .inf_b        (inf_b),
    .zero_a       (zero_a),
    .zero_b       (zero_b),
    .fmt          (fmt),
    .exc_hit      (exc_hit),
    .exc_sign     (exc_sign),
    .exc_exp_ones (exc_exp_ones),
    .exc_nan      (exc_nan),
    .exc_flags    (exc_flags)
  );

  mant_norm_round u_mant_norm_round (
    .sign_in  (sign_in),
    .exp_in   (exp_in),
    .mant_in  (mant_in),
    .rm       (rm),
    .fmt      (fmt),
    .rnd_exp  (rnd_exp),
    .rnd_mant (rnd_mant),
    .rnd_uf   (rnd_uf),
    .rnd_nx   (rnd_nx)
  );

  result_pack #(
    .pipe_stages (pipe_stages)
  ) u_result_pack (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .sign_in      (sign_in),
    .fmt          (fmt),
    .exc_hit      (exc_hit),
    .exc_sign     (exc_sign),
    .exc_exp_ones (exc_exp_ones),
    .exc_nan      (exc_nan),
    .exc_flags    (exc_flags),
    .rnd_exp      (rnd_exp),
    .rnd_mant     (rnd_mant),
    .rnd_uf       (rnd_uf),
    .rnd_nx       (rnd_nx),
    .out_valid    (out_valid),
    .result       (result),
    .fflags       (fflags)
  );

endmodule

/* testbench/tb_fp_norm_round.sv */
`timescale 1ns/10ps

module tb_fp_norm_round
  import fp_fmt_pkg::*;
  import fp_round_pkg::*;
();

  localparam int pipe_stages = 2;
  localparam int n_tests     = 6;
  localparam int max_ops     = 20;   // Per test, upper bound
  localparam int wd_cycles   = n_tests * max_ops * (pipe_stages + 4) + 200;
  localparam int lat_limit   = pipe_stages + 4;

  // Operand class bits, {div, sqrt, nan_a, nan_b, snan, inf_a, inf_b, zero_a, zero_b}
  localparam logic [8:0] cl_none   = 9'h000;
  localparam logic [8:0] cl_div    = 9'h100;
  localparam logic [8:0] cl_sqrt   = 9'h080;
  localparam logic [8:0] cl_nan_a  = 9'h040;
  localparam logic [8:0] cl_nan_b  = 9'h020;
  localparam logic [8:0] cl_snan   = 9'h010;
  localparam logic [8:0] cl_inf_a  = 9'h008;
  localparam logic [8:0] cl_inf_b  = 9'h004;
  localparam logic [8:0] cl_zero_a = 9'h002;
  localparam logic [8:0] cl_zero_b = 9'h001;

  // One-hot flag words
  localparam logic [4:0] fl_nv = 5'(1) << flag_nv;
  localparam logic [4:0] fl_dz = 5'(1) << flag_dz;
  localparam logic [4:0] fl_of = 5'(1) << flag_of;
  localparam logic [4:0] fl_uf = 5'(1) << flag_uf;
  localparam logic [4:0] fl_nx = 5'(1) << flag_nx;

  logic                       clk;
  logic                       rst_n;
  logic                       in_valid;
  logic                       sign_in;
  logic signed [exp_in_w-1:0] exp_in;
  logic [mant_in_w-1:0]       mant_in;
  logic                       div_en;
  logic                       sqrt_en;
  logic                       nan_a;
  logic                       nan_b;
  logic                       snan;
  logic                       inf_a;
  logic                       inf_b;
  logic                       zero_a;
  logic                       zero_b;
  logic [1:0]                 rm;
  logic                       fmt;
  logic                       out_valid;
  fp_word_u                   result;
  logic [4:0]                 fflags;

  int err_word;
  int err_flags;
  int err_lat;
  int err_proto;
  int cyc;      // Rising edges since time zero

  fp_norm_round_top #(
    .pipe_stages (pipe_stages)
  ) u_fp_norm_round_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .sign_in   (sign_in),
    .exp_in    (exp_in),
    .mant_in   (mant_in),
    .div_en    (div_en),
    .sqrt_en   (sqrt_en),
    .nan_a     (nan_a),
    .nan_b     (nan_b),
    .snan      (snan),
    .inf_a     (inf_a),
    .inf_b     (inf_b),
    .zero_a    (zero_a),
    .zero_b    (zero_b),
    .rm        (rm),
    .fmt       (fmt),
    .out_valid (out_valid),
    .result    (result),
    .fflags    (fflags)
  );

  ////////////////////////////////////////
  // Clock, cycle count, watchdog
  ////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk)
    cyc <= cyc + 1;

  initial
  begin
    repeat (wd_cycles) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", wd_cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // Checks and expected values
  ////////////////////////////////////////

  task automatic check_word(input string name, input fp_word_u exp_w, input fp_word_u act);
    if (act !== exp_w)
    begin
      $display("ERR %s: result expected %08h, actual %08h", name, exp_w, act);
      err_word++;
    end
  endtask

  task automatic check_flags(input string name, input logic [4:0] exp_f, input logic [4:0] act);
    if (act !== exp_f)
    begin
      $display("ERR %s: fflags expected %05b, actual %05b", name, exp_f, act);
      err_flags++;
    end
  endtask

  task automatic check_latency(input string name, input int exp_c, input int act);
    if (act != exp_c)
    begin
      $display("ERR %s: cycle expected %0d, actual %0d", name, exp_c, act);
      err_lat++;
    end
  endtask

  function automatic fp_word_u pack32(input logic s, input logic [7:0] e, input logic [22:0] m);
    fp_word_u w;
    w.fp32.sign = s;
    w.fp32.exp  = e;
    w.fp32.mant = m;
    return w;
  endfunction

  function automatic fp_word_u pack16(input logic s, input logic [4:0] e, input logic [9:0] m);
    fp_word_u w;
    w.fp16.box  = box16;
    w.fp16.sign = s;
    w.fp16.exp  = e;
    w.fp16.mant = m;
    return w;
  endfunction

  // Round-up decision per mode
  function automatic logic ref_up(input logic [1:0] mode, input logic s, input logic lsb,
                                  input logic g, input logic r, input logic st);
    case (mode)
      rm_nearest_even: return g & (r | st | lsb);
      rm_to_zero:      return 1'b0;
      rm_plus_inf:     return (g | r | st) & ~s;
      default:         return (g | r | st) & s;
    endcase
  endfunction

  // Model for normal exponents, 1.x or 0.1x inputs
  task automatic ref_normal(input logic s, input int e, input logic [27:0] m,
                            input logic [1:0] mode, input logic f,
                            output fp_word_u w, output logic [4:0] fl);
    logic [27:0] n;
    int          ne;
    logic [24:0] sum32;
    logic [11:0] sum16;
    logic        g;
    logic        r;
    logic        st;
    logic        up;
    if (m[27])
    begin
      n  = m;
      ne = e;
    end
    else
    begin
      n  = m << 1;   // 0.1x up to 1.x
      ne = e - 1;
    end
    if (f == fmt_fp32)
    begin
      g     = n[3];
      r     = n[2];
      st    = |n[1:0];
      up    = ref_up(mode, s, n[4], g, r, st);
      sum32 = {1'b0, n[27:4]} + 25'(up);
      if (sum32[24])
        w = pack32(s, 8'(ne + 1), sum32[23:1]);   // Carry renormalizes
      else
        w = pack32(s, 8'(ne), sum32[22:0]);
    end
    else
    begin
      g     = n[16];
      r     = n[15];
      st    = |n[14:0];
      up    = ref_up(mode, s, n[17], g, r, st);
      sum16 = {1'b0, n[27:17]} + 12'(up);
      if (sum16[11])
        w = pack16(s, 5'(ne + 1), sum16[10:1]);
      else
        w = pack16(s, 5'(ne), sum16[9:0]);
    end
    fl          = '0;
    fl[flag_nx] = g | r | st;
  endtask

  ////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////

  task automatic drive(input logic s, input int e, input logic [27:0] m,
                       input logic [1:0] mode, input logic f, input logic [8:0] cls);
    sign_in = s;
    exp_in  = exp_in_w'(e);
    mant_in = m;
    rm      = mode;
    fmt     = f;
    {div_en, sqrt_en, nan_a, nan_b, snan, inf_a, inf_b, zero_a, zero_b} = cls;
  endtask

  // One operation, then wait for its out_valid
  task automatic run_op(input string name, input logic s, input int e, input logic [27:0] m,
                        input logic [1:0] mode, input logic f, input logic [8:0] cls,
                        input fp_word_u exp_w, input logic [4:0] exp_f);
    int   lat;
    logic got;
    @(negedge clk);
    drive(s, e, m, mode, f, cls);
    in_valid = 1'b1;
    lat      = 0;
    got      = 1'b0;
    while (!got && lat < lat_limit)
    begin
      @(negedge clk);
      in_valid = 1'b0;
      lat++;
      got = out_valid;
    end
    if (!got)
    begin
      $display("%s: out_valid never came within %0d cycles", name, lat_limit);
      err_proto++;
    end
    else
    begin
      check_latency(name, pipe_stages, lat);
      check_word(name, exp_w, result);
      check_flags(name, exp_f, fflags);
    end
  endtask

  task automatic run_norm(input string name, input logic s, input int e, input logic [27:0] m,
                          input logic [1:0] mode, input logic f);
    fp_word_u   w;
    logic [4:0] fl;
    ref_normal(s, e, m, mode, f, w, fl);
    run_op(name, s, e, m, mode, f, cl_none, w, fl);
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic test_reset_latency();
    if (out_valid !== 1'b0)
    begin
      $display("reset: out_valid is not low after reset");
      err_proto++;
    end
    check_word("reset", '0, result);
    check_flags("reset", 5'b0, fflags);
    run_op("latency", 1'b0, 127, 28'hA000000, rm_nearest_even, fmt_fp32, cl_none,
           pack32(1'b0, 8'd127, 23'h200000), 5'b0);
  endtask

  task automatic test_round_modes();
    logic [27:0] ops [2];
    ops[0] = 28'h8000018;   // Odd LSB, guard only
    ops[1] = 28'h8000008;   // Even LSB, guard only
    for (int mode = 0; mode < 4; mode++)
    begin
      for (int s = 0; s < 2; s++)
      begin
        for (int k = 0; k < 2; k++)
          run_norm("round_modes", 1'(s), 127, ops[k], 2'(mode), fmt_fp32);
      end
    end
    // All-ones kept field carries into the exponent
    run_op("round_carry", 1'b0, 127, 28'hFFFFFF8, rm_nearest_even, fmt_fp32, cl_none,
           pack32(1'b0, 8'd128, 23'h0), fl_nx);
  endtask

  task automatic test_fp16_box();
    run_op("fp16_box", 1'b0, 15, 28'hA030000, rm_nearest_even, fmt_fp16, cl_none,
           pack16(1'b0, 5'd15, 10'h102), fl_nx);
    run_norm("fp16_box", 1'b1, 12, 28'h6ABCDEF, rm_minus_inf, fmt_fp16);
  endtask

  task automatic test_special();
    fp_word_u qnan;
    fp_word_u ninf;
    fp_word_u nzero;
    qnan  = pack32(1'b0, 8'hff, canon_nan_mant32);
    ninf  = pack32(1'b1, 8'hff, 23'h0);
    nzero = pack32(1'b1, 8'h00, 23'h0);
    run_op("nan_snan", 1'b1, 127, 28'h8000000, rm_nearest_even, fmt_fp32,
           cl_nan_a | cl_snan, qnan, fl_nv);
    run_op("nan_quiet", 1'b1, 127, 28'h8000000, rm_nearest_even, fmt_fp32,
           cl_nan_b, qnan, 5'b0);
    run_op("inf_inf", 1'b1, 127, 28'h8000000, rm_nearest_even, fmt_fp32,
           cl_div | cl_inf_a | cl_inf_b, qnan, fl_nv);
    run_op("inf_a", 1'b1, 127, 28'h8000000, rm_nearest_even, fmt_fp32,
           cl_inf_a, ninf, fl_of);
    run_op("div_by_inf", 1'b1, 127, 28'h8000000, rm_nearest_even, fmt_fp32,
           cl_div | cl_inf_b, nzero, 5'b0);
    run_op("zero_zero", 1'b1, 127, 28'h8000000, rm_nearest_even, fmt_fp32,
           cl_div | cl_zero_a | cl_zero_b, qnan, fl_nv | fl_dz);
    run_op("zero_a", 1'b1, 127, 28'h8000000, rm_nearest_even, fmt_fp32,
           cl_zero_a, nzero, 5'b0);
    run_op("div_by_zero", 1'b1, 127, 28'h8000000, rm_nearest_even, fmt_fp32,
           cl_div | cl_zero_b, ninf, fl_dz);
    run_op("sqrt_neg", 1'b1, 127, 28'h8000000, rm_nearest_even, fmt_fp32,
           cl_sqrt, qnan, fl_nv);
    run_op("exp_ovf", 1'b1, 255, 28'h8000000, rm_nearest_even, fmt_fp32,
           cl_div, ninf, fl_of);
    run_op("exp_tuf", 1'b1, -24, 28'h8000000, rm_nearest_even, fmt_fp32,
           cl_div, nzero, fl_uf | fl_nx);
  endtask

  // Denormal result, shifted right by 1 - e and truncated
  task automatic run_denorm(input int e);
    logic [27:0] m;
    logic [27:0] shifted;
    logic        lost;
    int          k;
    logic [4:0]  fl;
    m       = 28'hC000000 | 28'($urandom() & 32'hff);   // Random low bits
    k       = 1 - e;
    shifted = m >> k;
    lost    = |(m & ((28'd1 << k) - 28'd1));
    fl      = fl_uf;
    if (lost || (|shifted[3:0]))
      fl = fl | fl_nx;
    run_op("denorm", 1'b0, e, m, rm_to_zero, fmt_fp32, cl_none,
           pack32(1'b0, 8'h00, shifted[26:4]), fl);
  endtask

  task automatic test_range();
    run_op("ovf_fp16", 1'b0, 31, 28'h8000000, rm_nearest_even, fmt_fp16, cl_none,
           pack16(1'b0, 5'h1f, 10'h0), fl_of);
    run_op("ovf_fp32", 1'b0, 300, 28'h8000000, rm_nearest_even, fmt_fp32, cl_none,
           pack32(1'b0, 8'hff, 23'h0), fl_of);
    run_op("tuf_fp16", 1'b1, -11, 28'h8000000, rm_nearest_even, fmt_fp16, cl_none,
           pack16(1'b1, 5'h0, 10'h0), fl_uf | fl_nx);
    run_denorm(-2);
    run_denorm(-5);
  endtask

  task automatic test_pipeline();
    fp_word_u    exp_w   [6];
    logic [4:0]  exp_f   [6];
    int          exp_cyc [6];   // Cycle count when each result is due
    logic        s;
    logic        f;
    logic [1:0]  mode;
    logic [27:0] m;
    int          e;
    int          n;
    int          waited;
    fork
      begin : drive_side
        for (int i = 0; i < 6; i++)
        begin
          @(negedge clk);
          if (i == 3)
          begin
            in_valid = 1'b0;   // One bubble
            @(negedge clk);
          end
          s    = 1'($urandom());
          f    = 1'($urandom());
          mode = 2'($urandom());
          m    = 28'($urandom());
          if (!m[27])
            m[26] = 1'b1;      // Keep it 0.1x at worst
          e = ((f == fmt_fp16) ? 10 : 120) + int'($urandom() % 8);
          ref_normal(s, e, m, mode, f, exp_w[i], exp_f[i]);
          exp_cyc[i] = cyc + pipe_stages;
          drive(s, e, m, mode, f, cl_none);
          in_valid = 1'b1;
        end
        @(negedge clk);
        in_valid = 1'b0;
      end
      begin : watch_side
        n      = 0;
        waited = 0;
        while (n < 6 && waited < 6 * lat_limit)
        begin
          @(negedge clk);
          waited++;
          if (out_valid)
          begin
            check_latency("pipeline", exp_cyc[n], cyc);
            check_word("pipeline", exp_w[n], result);
            check_flags("pipeline", exp_f[n], fflags);
            n++;
          end
        end
        if (n < 6)
        begin
          $display("pipeline: only %0d of 6 results came out", n);
          err_proto++;
        end
      end
    join
  endtask

  ////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////

  initial
  begin
    void'($urandom(18));
    cyc       = 0;
    err_word  = 0;
    err_flags = 0;
    err_lat   = 0;
    err_proto = 0;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    drive(1'b0, 0, 28'h0, rm_nearest_even, fmt_fp32, cl_none);
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    test_reset_latency();
    test_round_modes();
    test_fp16_box();
    test_special();
    test_range();
    test_pipeline();

    @(negedge clk);
    $display("Errors: result %0d, flags %0d, latency %0d, protocol %0d",
             err_word, err_flags, err_lat, err_proto);
    if ((err_word + err_flags + err_lat + err_proto) == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* src.f */
hdl/fp_fmt_pkg.sv
hdl/fp_round_pkg.sv
hdl/exc_classify.sv
hdl/mant_norm_round.sv
hdl/result_pack.sv
hdl/fp_norm_round_top.sv
testbench/tb_fp_norm_round.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fp_norm_round
RTL_TOP   ?= fp_norm_round_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
